/* sources.f */
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_lane.sv
hdl/exec_operand_read.sv
hdl/exec_writeback.sv
hdl/exec_cluster.sv
testbench/tb_exec_cluster.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - hdl/exec_pkg.sv
  - hdl/exec_alu.sv
  - hdl/exec_lane.sv
  - hdl/exec_operand_read.sv
  - hdl/exec_writeback.sv
  - hdl/exec_cluster.sv
  - target: test
    files:
      - testbench/tb_exec_cluster.sv

/* testbench/tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

    localparam int N = exec_pkg::NUM_LANES;
    // Cycles per test, drain included: idle, directed, chain, same rd, r0, random
    localparam int TEST_CYCLES = 24 + 166 + 23 + 7 + 6 + 402;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + RESET_CYCLES;

    typedef struct packed {
        logic [N-1:0]               valid;
        exec_pkg::reg_idx_t [N-1:0] rd;
        exec_pkg::data_t [N-1:0]    data;
    } retire_exp_t;

    logic clk = 1'b0;
    logic rst_n_i;
    logic issue_valid [N-1:0];
    exec_pkg::alu_class_e issue_class [N-1:0];
    exec_pkg::alu_op_t issue_op [N-1:0];
    exec_pkg::reg_idx_t issue_rd [N-1:0];
    exec_pkg::reg_idx_t issue_rj [N-1:0];
    exec_pkg::reg_idx_t issue_rk [N-1:0];
    exec_pkg::data_t issue_imm [N-1:0];
    logic issue_use_imm [N-1:0];
    exec_pkg::data_t issue_pc [N-1:0];
    logic retire_valid [N-1:0];
    exec_pkg::reg_idx_t retire_rd [N-1:0];
    exec_pkg::data_t retire_data [N-1:0];

    // Next bundle, filled by set_op
    logic st_valid [N-1:0];
    exec_pkg::alu_class_e st_class [N-1:0];
    exec_pkg::alu_op_t st_op [N-1:0];
    exec_pkg::reg_idx_t st_rd [N-1:0];
    exec_pkg::reg_idx_t st_rj [N-1:0];
    exec_pkg::reg_idx_t st_rk [N-1:0];
    exec_pkg::data_t st_imm [N-1:0];
    logic st_use_imm [N-1:0];

    exec_pkg::data_t model_rf [32];
    retire_exp_t exp_q [$];
    retire_exp_t check_entry;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int test_base = 0;
    int bundle_cnt = 0;
    int cycle_cnt = 0;
    logic [31:0] seed = 32'h32360bf9;
    logic [31:0] r;
    logic [31:0] r2;
    exec_pkg::data_t load_val [8] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h1,
                                      32'h1234_5678, 32'd31, 32'd32, 32'hf0f0_0f0f};
    exec_pkg::reg_idx_t pair_rj [8] = '{1, 2, 3, 4, 5, 5, 1, 3};
    exec_pkg::reg_idx_t pair_rk [8] = '{2, 1, 4, 3, 6, 7, 1, 8};

    always #50 clk = ~clk;

    exec_cluster dut (
        .clk_i (clk), .rst_n_i (rst_n_i),
        .issue_valid_i (issue_valid), .issue_class_i (issue_class), .issue_op_i (issue_op),
        .issue_rd_i (issue_rd), .issue_rj_i (issue_rj), .issue_rk_i (issue_rk),
        .issue_imm_i (issue_imm), .issue_use_imm_i (issue_use_imm), .issue_pc_i (issue_pc),
        .retire_valid_o (retire_valid), .retire_rd_o (retire_rd), .retire_data_o (retire_data)
    );

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);   // Low LCG bits are weak
    endfunction

    function automatic exec_pkg::data_t alu_ref(exec_pkg::alu_class_e cls, exec_pkg::alu_op_t op,
                                                exec_pkg::data_t a, exec_pkg::data_t b,
                                                exec_pkg::data_t pc);
        logic [4:0] s;
        logic lt;
        logic ltu;
        s = b[4:0];
        lt = $signed(a) < $signed(b);
        ltu = a < b;
        case (cls)
            exec_pkg::CLASS_BW: begin
                case (op)
                    exec_pkg::AND: return a & b;
                    exec_pkg::OR: return a | b;
                    exec_pkg::NOR: return ~(a | b);
                    exec_pkg::XOR: return a ^ b;
                    exec_pkg::ANDN: return a & ~b;
                    exec_pkg::ORN: return a | ~b;
                    default: return '0;
                endcase
            end
            exec_pkg::CLASS_LI: begin
                if (op == exec_pkg::LUI) return {a[19:0], 12'h000};
                if (op == exec_pkg::PCADDU12I) return {a[19:0], 12'h000} + pc;
                return '0;
            end
            exec_pkg::CLASS_INT: begin
                case (op)
                    exec_pkg::ADD: return a + b;
                    exec_pkg::SUB: return a - b;
                    exec_pkg::SLT: return lt ? 32'd1 : 32'd0;
                    exec_pkg::SLTU: return ltu ? 32'd1 : 32'd0;
                    default: return '0;
                endcase
            end
            exec_pkg::CLASS_SFT: begin
                case (op)
                    exec_pkg::SLL, exec_pkg::SLA: return a << s;
                    exec_pkg::SRL: return a >> s;
                    exec_pkg::SRA: return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
                    default: return '0;
                endcase
            end
            exec_pkg::CLASS_COM: begin
                case (op)
                    exec_pkg::EQ: return (a == b) ? 32'd1 : 32'd0;
                    exec_pkg::NE: return (a != b) ? 32'd1 : 32'd0;
                    exec_pkg::LT: return lt ? 32'd1 : 32'd0;
                    exec_pkg::GE: return lt ? 32'd0 : 32'd1;
                    exec_pkg::LTU: return ltu ? 32'd1 : 32'd0;
                    exec_pkg::GEU: return ltu ? 32'd0 : 32'd1;
                    default: return '0;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic compare_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic compare_rd(input string name, input exec_pkg::reg_idx_t got,
                              input exec_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic compare_data(input string name, input exec_pkg::data_t got,
                                input exec_pkg::data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic set_op(input int l, input exec_pkg::alu_class_e cls, input exec_pkg::alu_op_t op,
                          input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t rj,
                          input exec_pkg::reg_idx_t rk, input exec_pkg::data_t imm,
                          input logic use_imm);
        st_valid[l] = 1'b1;
        st_class[l] = cls;
        st_op[l] = op;
        st_rd[l] = rd;
        st_rj[l] = rj;
        st_rk[l] = rk;
        st_imm[l] = imm;
        st_use_imm[l] = use_imm;
    endtask

    task automatic load_reg(input int l, input exec_pkg::reg_idx_t rd, input exec_pkg::data_t val);
        set_op(l, exec_pkg::CLASS_INT, exec_pkg::ADD, rd, 5'd0, 5'd0, val, 1'b1);
    endtask

    // Drives the staged bundle, predicts its retire, then updates the model in lane order
    task automatic issue_bundle();
        exec_pkg::data_t s0;
        exec_pkg::data_t s1;
        exec_pkg::data_t pc;
        exec_pkg::data_t res [N];
        retire_exp_t e;
        @(posedge clk);
        bundle_cnt++;
        for (int l = 0; l < N; l++) begin
            pc = 32'h1c00_0000 + (bundle_cnt << 3) + (l << 2);
            s0 = (st_class[l] == exec_pkg::CLASS_LI) ? st_imm[l] : model_rf[st_rj[l]];
            s1 = st_use_imm[l] ? st_imm[l] : model_rf[st_rk[l]];
            res[l] = alu_ref(st_class[l], st_op[l], s0, s1, pc);
            e.valid[l] = st_valid[l];
            e.rd[l] = st_rd[l];
            e.data[l] = res[l];
            issue_valid[l] <= st_valid[l];
            issue_class[l] <= st_class[l];
            issue_op[l] <= st_op[l];
            issue_rd[l] <= st_rd[l];
            issue_rj[l] <= st_rj[l];
            issue_rk[l] <= st_rk[l];
            issue_imm[l] <= st_imm[l];
            issue_use_imm[l] <= st_use_imm[l];
            issue_pc[l] <= pc;
        end
        for (int l = 0; l < N; l++) begin
            if (st_valid[l] && (st_rd[l] != 5'd0)) begin
                model_rf[st_rd[l]] = res[l];
            end
            st_valid[l] = 1'b0;
        end
        exp_q.push_back(e);
    endtask

    task automatic end_test(input string name);
        issue_bundle();
        issue_bundle();
        @(negedge clk);
        #1;
        $display("%s finished with %0d errors", name, fail_cnt - test_base);
        test_base = fail_cnt;
    endtask

    // Retire of the bundle driven one edge earlier
    always @(negedge clk) begin
        if (rst_n_i && (exp_q.size() > 1)) begin
            check_entry = exp_q.pop_front();
            for (int l = 0; l < N; l++) begin
                compare_valid($sformatf("retire_valid_o[%0d]", l), retire_valid[l],
                              check_entry.valid[l]);
                if (check_entry.valid[l]) begin
                    compare_rd($sformatf("retire_rd_o[%0d]", l), retire_rd[l], check_entry.rd[l]);
                    compare_data($sformatf("retire_data_o[%0d]", l), retire_data[l],
                                 check_entry.data[l]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        for (int l = 0; l < N; l++) begin
            issue_valid[l] = 1'b0;
            issue_class[l] = exec_pkg::CLASS_BW;
            issue_op[l] = '0;
            issue_rd[l] = '0;
            issue_rj[l] = '0;
            issue_rk[l] = '0;
            issue_imm[l] = '0;
            issue_use_imm[l] = 1'b0;
            issue_pc[l] = '0;
            st_valid[l] = 1'b0;
            set_op(l, exec_pkg::CLASS_BW, '0, '0, '0, '0, '0, 1'b0);
            st_valid[l] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        repeat (6) issue_bundle();
        for (int i = 0; i < 16; i++) begin
            set_op(0, exec_pkg::CLASS_BW, exec_pkg::OR, 5'd0, 5'(2 * i), 5'(2 * i + 1), '0, 1'b0);
            set_op(1, exec_pkg::CLASS_INT, exec_pkg::ADD, 5'd0, 5'(31 - 2 * i), 5'(30 - 2 * i),
                   '0, 1'b0);
            issue_bundle();
        end
        end_test("reset_idle");

        for (int i = 0; i < 4; i++) begin
            load_reg(0, 5'(2 * i + 1), load_val[2 * i]);
            load_reg(1, 5'(2 * i + 2), load_val[2 * i + 1]);
            issue_bundle();
        end
        for (int c = 0; c < 5; c++) begin
            for (int o = 0; o < 8; o++) begin
                for (int p = 0; p < 4; p++) begin
                    set_op(0, exec_pkg::alu_class_e'(c), exec_pkg::alu_op_t'(o), 5'(16 + p),
                           pair_rj[2 * p], pair_rk[2 * p], 32'h000a_b000 + p, 1'b0);
                    set_op(1, exec_pkg::alu_class_e'(c), exec_pkg::alu_op_t'(o), 5'(20 + p),
                           pair_rj[2 * p + 1], pair_rk[2 * p + 1], 32'hfff8_7001 - p, p == 3);
                    issue_bundle();
                end
            end
        end
        end_test("directed");

        load_reg(0, 5'd10, 32'd5);
        load_reg(1, 5'd5, 32'h1234_5678);
        issue_bundle();
        for (int k = 0; k < 20; k++) begin
            if (k % 2 == 0) begin
                set_op(0, exec_pkg::CLASS_INT, exec_pkg::ADD, 5'd10, 5'd10, 5'd0, k + 1, 1'b1);
            end else begin
                set_op(1, exec_pkg::CLASS_BW, exec_pkg::XOR, 5'd10, 5'd5, 5'd10, '0, 1'b0);
            end
            issue_bundle();
        end
        end_test("bypass_chain");

        load_reg(0, 5'd12, 32'h111);
        load_reg(1, 5'd12, 32'h222);
        issue_bundle();
        set_op(0, exec_pkg::CLASS_BW, exec_pkg::OR, 5'd13, 5'd12, 5'd0, '0, 1'b0);
        issue_bundle();
        load_reg(0, 5'd14, 32'haaa);
        set_op(1, exec_pkg::CLASS_BW, exec_pkg::OR, 5'd15, 5'd14, 5'd0, '0, 1'b0);
        issue_bundle();
        issue_bundle();
        set_op(0, exec_pkg::CLASS_BW, exec_pkg::OR, 5'd17, 5'd12, 5'd14, '0, 1'b0);
        set_op(1, exec_pkg::CLASS_INT, exec_pkg::SUB, 5'd18, 5'd14, 5'd12, '0, 1'b0);
        issue_bundle();
        end_test("same_rd");

        load_reg(0, 5'd0, 32'h5a5a);
        set_op(1, exec_pkg::CLASS_LI, exec_pkg::LUI, 5'd0, 5'd0, 5'd0, 32'h77, 1'b0);
        issue_bundle();
        set_op(0, exec_pkg::CLASS_BW, exec_pkg::OR, 5'd16, 5'd0, 5'd0, '0, 1'b0);
        issue_bundle();
        issue_bundle();
        set_op(0, exec_pkg::CLASS_INT, exec_pkg::ADD, 5'd18, 5'd0, 5'd0, '0, 1'b0);
        load_reg(1, 5'd0, 32'hdead);
        issue_bundle();
        end_test("r0_write");

        for (int i = 0; i < 400; i++) begin
            for (int l = 0; l < N; l++) begin
                r = next_random();
                r2 = next_random();
                if (r[31]) begin
                    set_op(l, exec_pkg::alu_class_e'(3'(r[3:0] % 6)), r[10:8], {1'b0, r[25], r[14:12]},
                           {2'b0, r[18:16]}, {2'b0, r[22:20]}, r2, r[24]);
                end
            end
            issue_bundle();
        end
        end_test("random");

        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 issue_valid_i   [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::alu_class_e issue_class_i   [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::alu_op_t    issue_op_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rd_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rj_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rk_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t      issue_imm_i     [exec_pkg::NUM_LANES-1:0],
    input  logic                 issue_use_imm_i [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t      issue_pc_i      [exec_pkg::NUM_LANES-1:0],

    output logic                 retire_valid_o  [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::reg_idx_t   retire_rd_o     [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t      retire_data_o   [exec_pkg::NUM_LANES-1:0]
);

    logic                 op_valid  [exec_pkg::NUM_LANES-1:0];
    exec_pkg::alu_class_e op_class  [exec_pkg::NUM_LANES-1:0];
    exec_pkg::alu_op_t    op_code   [exec_pkg::NUM_LANES-1:0];
    exec_pkg::reg_idx_t   op_rd     [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t      src0      [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t      src1      [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t      op_pc     [exec_pkg::NUM_LANES-1:0];

    logic                 lane_valid [exec_pkg::NUM_LANES-1:0];
    exec_pkg::reg_idx_t   lane_rd    [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t      lane_data  [exec_pkg::NUM_LANES-1:0];

    logic                 wr_en      [exec_pkg::NUM_LANES-1:0];
    exec_pkg::reg_idx_t   wr_idx     [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t      wr_data    [exec_pkg::NUM_LANES-1:0];

    exec_operand_read u_operand_read (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_class_i   (issue_class_i),
        .issue_op_i      (issue_op_i),
        .issue_rd_i      (issue_rd_i),
        .issue_rj_i      (issue_rj_i),
        .issue_rk_i      (issue_rk_i),
        .issue_imm_i     (issue_imm_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_pc_i      (issue_pc_i),
        .wr_en_i         (wr_en),      // Also feeds the bypass
        .wr_idx_i        (wr_idx),
        .wr_data_i       (wr_data),
        .op_valid_o      (op_valid),
        .op_class_o      (op_class),
        .op_code_o       (op_code),
        .op_rd_o         (op_rd),
        .src0_o          (src0),
        .src1_o          (src1),
        .pc_o            (op_pc)
    );

    for (genvar l = 0; l < exec_pkg::NUM_LANES; l++) begin : g_lane
        exec_lane u_lane (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .valid_i (op_valid[l]),
            .class_i (op_class[l]),
            .op_i    (op_code[l]),
            .rd_i    (op_rd[l]),
            .src0_i  (src0[l]),
            .src1_i  (src1[l]),
            .pc_i    (op_pc[l]),
            .valid_o (lane_valid[l]),
            .rd_o    (lane_rd[l]),
            .data_o  (lane_data[l])
        );
    end

    exec_writeback u_writeback (
        .lane_valid_i   (lane_valid),
        .lane_rd_i      (lane_rd),
        .lane_data_i    (lane_data),
        .wr_en_o        (wr_en),
        .wr_idx_o       (wr_idx),
        .wr_data_o      (wr_data),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

/* hdl/exec_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_writeback (
    input  logic               lane_valid_i   [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t lane_rd_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t    lane_data_i    [exec_pkg::NUM_LANES-1:0],

    output logic               wr_en_o        [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::reg_idx_t wr_idx_o       [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t    wr_data_o      [exec_pkg::NUM_LANES-1:0],

    output logic               retire_valid_o [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::reg_idx_t retire_rd_o    [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t    retire_data_o  [exec_pkg::NUM_LANES-1:0]
);

    logic overridden [exec_pkg::NUM_LANES-1:0];

    // A later lane to the same register hides this one
    always_comb begin
        for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
            overridden[l] = 1'b0;
            for (int h = l + 1; h < exec_pkg::NUM_LANES; h++) begin
                if (lane_valid_i[h] && (lane_rd_i[h] == lane_rd_i[l])) begin
                    overridden[l] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
            wr_en_o[l]   = lane_valid_i[l] && (lane_rd_i[l] != '0) && !overridden[l];
            wr_idx_o[l]  = lane_rd_i[l];
            wr_data_o[l] = lane_data_i[l];
        end
    end

    // Every valid result retires, r0 included
    always_comb begin
        for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
            retire_valid_o[l] = lane_valid_i[l];
            retire_rd_o[l]    = lane_rd_i[l];
            retire_data_o[l]  = lane_data_i[l];
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_operand_read.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_operand_read (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 issue_valid_i   [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::alu_class_e issue_class_i   [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::alu_op_t    issue_op_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rd_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rj_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   issue_rk_i      [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t      issue_imm_i     [exec_pkg::NUM_LANES-1:0],
    input  logic                 issue_use_imm_i [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t      issue_pc_i      [exec_pkg::NUM_LANES-1:0],

    input  logic                 wr_en_i         [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::reg_idx_t   wr_idx_i        [exec_pkg::NUM_LANES-1:0],
    input  exec_pkg::data_t      wr_data_i       [exec_pkg::NUM_LANES-1:0],

    output logic                 op_valid_o      [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::alu_class_e op_class_o      [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::alu_op_t    op_code_o       [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::reg_idx_t   op_rd_o         [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t      src0_o          [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t      src1_o          [exec_pkg::NUM_LANES-1:0],
    output exec_pkg::data_t      pc_o            [exec_pkg::NUM_LANES-1:0]
);

    // Entry 0 is not stored
    exec_pkg::data_t rf_q   [exec_pkg::REG_NUM-1:1];
    exec_pkg::data_t rj_val [exec_pkg::NUM_LANES-1:0];
    exec_pkg::data_t rk_val [exec_pkg::NUM_LANES-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < exec_pkg::REG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < exec_pkg::NUM_LANES; w++) begin
                if (wr_en_i[w] && (wr_idx_i[w] != '0)) begin
                    rf_q[wr_idx_i[w]] <= wr_data_i[w];
                end
            end
        end
    end

    // Array read, then the pending write overrides it
    always_comb begin
        for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
            rj_val[l] = '0;
            rk_val[l] = '0;
            if (issue_rj_i[l] != '0) begin
                rj_val[l] = rf_q[issue_rj_i[l]];
            end
            if (issue_rk_i[l] != '0) begin
                rk_val[l] = rf_q[issue_rk_i[l]];
            end
            // Higher lane checked last so it wins
            for (int w = 0; w < exec_pkg::NUM_LANES; w++) begin
                if (wr_en_i[w] && (issue_rj_i[l] != '0) && (wr_idx_i[w] == issue_rj_i[l])) begin
                    rj_val[l] = wr_data_i[w];
                end
                if (wr_en_i[w] && (issue_rk_i[l] != '0) && (wr_idx_i[w] == issue_rk_i[l])) begin
                    rk_val[l] = wr_data_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
            if (issue_class_i[l] == exec_pkg::CLASS_LI) begin
                src0_o[l] = issue_imm_i[l];
            end else if (issue_rj_i[l] == '0) begin
                src0_o[l] = '0;
            end else begin
                src0_o[l] = rj_val[l];
            end
            src1_o[l] = issue_use_imm_i[l] ? issue_imm_i[l] : rk_val[l];
        end
    end

    for (genvar l = 0; l < exec_pkg::NUM_LANES; l++) begin : g_pass
        assign op_valid_o[l] = issue_valid_i[l];
        assign op_class_o[l] = issue_class_i[l];
        assign op_code_o[l]  = issue_op_i[l];
        assign op_rd_o[l]    = issue_rd_i[l];
        assign pc_o[l]       = issue_pc_i[l];
    end

endmodule

`default_nettype wire

/* hdl/exec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  exec_pkg::alu_class_e class_i,
    input  exec_pkg::alu_op_t    op_i,
    input  exec_pkg::reg_idx_t   rd_i,
    input  exec_pkg::data_t      src0_i,
    input  exec_pkg::data_t      src1_i,
    input  exec_pkg::data_t      pc_i,
    output logic                 valid_o,
    output exec_pkg::reg_idx_t   rd_o,
    output exec_pkg::data_t      data_o
);

    exec_pkg::data_t    alu_result;
    logic               valid_q;
    exec_pkg::reg_idx_t rd_q;
    exec_pkg::data_t    data_q;

    exec_alu u_alu (
        .r0_i     (src0_i),
        .r1_i     (src1_i),
        .pc_i     (pc_i),
        .class_i  (class_i),
        .op_i     (op_i),
        .result_o (alu_result)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin   // Payload held when idle
            rd_q   <= rd_i;
            data_q <= alu_result;
        end
    end

    assign valid_o = valid_q;
    assign rd_o    = rd_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

/* hdl/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::data_t      r0_i,
    input  exec_pkg::data_t      r1_i,
    input  exec_pkg::data_t      pc_i,
    input  exec_pkg::alu_class_e class_i,
    input  exec_pkg::alu_op_t    op_i,
    output exec_pkg::data_t      result_o
);

    exec_pkg::data_t bw_result;
    exec_pkg::data_t li_result;
    exec_pkg::data_t int_result;
    exec_pkg::data_t sft_result;
    exec_pkg::data_t com_result;
    exec_pkg::data_t sub_result;
    exec_pkg::data_t imm_hi;
    logic            lt_s;
    logic            lt_u;
    logic            com_flag;
    logic [4:0]      shamt;

    // Shared by SUB, EQ and NE
    assign sub_result = r0_i - r1_i;
    assign lt_s       = $signed(r0_i) < $signed(r1_i);
    assign lt_u       = r0_i < r1_i;
    assign shamt      = r1_i[4:0];
    assign imm_hi     = {r0_i[19:0], 12'b0};

    always_comb begin
        case (class_i)
            exec_pkg::CLASS_BW:  result_o = bw_result;
            exec_pkg::CLASS_LI:  result_o = li_result;
            exec_pkg::CLASS_INT: result_o = int_result;
            exec_pkg::CLASS_SFT: result_o = sft_result;
            exec_pkg::CLASS_COM: result_o = com_result;
            default: begin
                result_o = '0;
            end
        endcase
    end

    always_comb begin
        case (exec_pkg::bw_op_e'(op_i))
            exec_pkg::AND:  bw_result = r0_i & r1_i;
            exec_pkg::OR:   bw_result = r0_i | r1_i;
            exec_pkg::NOR:  bw_result = ~(r0_i | r1_i);
            exec_pkg::XOR:  bw_result = r0_i ^ r1_i;
            exec_pkg::ANDN: bw_result = r0_i & ~r1_i;
            exec_pkg::ORN:  bw_result = r0_i | ~r1_i;
            default: begin
                bw_result = '0;
            end
        endcase
    end

    // Immediate arrives on r0
    always_comb begin
        case (exec_pkg::li_op_e'(op_i))
            exec_pkg::LUI:       li_result = imm_hi;
            exec_pkg::PCADDU12I: li_result = imm_hi + pc_i;
            default: begin
                li_result = '0;
            end
        endcase
    end

    always_comb begin
        case (exec_pkg::int_op_e'(op_i))
            exec_pkg::ADD:  int_result = r0_i + r1_i;
            exec_pkg::SUB:  int_result = sub_result;
            exec_pkg::SLT:  int_result = exec_pkg::data_t'(lt_s);
            exec_pkg::SLTU: int_result = exec_pkg::data_t'(lt_u);
            default: begin
                int_result = '0;
            end
        endcase
    end

    always_comb begin
        case (exec_pkg::sft_op_e'(op_i))
            exec_pkg::SLL: sft_result = r0_i << shamt;
            exec_pkg::SRL: sft_result = r0_i >> shamt;
            exec_pkg::SLA: sft_result = $signed(r0_i) <<< shamt;   // Same bits as SLL
            exec_pkg::SRA: sft_result = $signed(r0_i) >>> shamt;
            default: begin
                sft_result = '0;
            end
        endcase
    end

    always_comb begin
        case (exec_pkg::com_op_e'(op_i))
            exec_pkg::EQ:  com_flag = (sub_result == '0);
            exec_pkg::NE:  com_flag = (sub_result != '0);
            exec_pkg::LT:  com_flag = lt_s;
            exec_pkg::GE:  com_flag = !lt_s;
            exec_pkg::LTU: com_flag = lt_u;
            exec_pkg::GEU: com_flag = !lt_u;
            default: begin
                com_flag = 1'b0;
            end
        endcase
        com_result = exec_pkg::data_t'(com_flag);
    end

endmodule

`default_nettype wire

/* hdl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int NUM_LANES = 2;
    localparam int XLEN      = 32;
    localparam int REG_NUM   = 32;
    localparam int REG_IDX_W = $clog2(REG_NUM);

    typedef logic [XLEN-1:0]      data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]           alu_op_t;   // Raw opcode field, decoded per class

    // Codes 5 to 7 are unused and give a zero result
    typedef enum logic [2:0] {
        CLASS_BW  = 3'd0,
        CLASS_LI  = 3'd1,
        CLASS_INT = 3'd2,
        CLASS_SFT = 3'd3,
        CLASS_COM = 3'd4
    } alu_class_e;

    typedef enum logic [2:0] {
        AND  = 3'd0,
        OR   = 3'd1,
        NOR  = 3'd2,
        XOR  = 3'd3,
        ANDN = 3'd4,
        ORN  = 3'd5
    } bw_op_e;

    typedef enum logic [2:0] {
        LUI       = 3'd0,
        PCADDU12I = 3'd1
    } li_op_e;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        SLT  = 3'd2,
        SLTU = 3'd3
    } int_op_e;

    typedef enum logic [2:0] {
        SLL = 3'd0,
        SRL = 3'd1,
        SLA = 3'd2,
        SRA = 3'd3
    } sft_op_e;

    typedef enum logic [2:0] {
        EQ  = 3'd0,
        NE  = 3'd1,
        LT  = 3'd2,
        GE  = 3'd3,
        LTU = 3'd4,
        GEU = 3'd5
    } com_op_e;

endpackage

`default_nettype wire
